/* design/pkt_filter_config.svh */
`ifndef PKT_FILTER_CONFIG_SVH
`define PKT_FILTER_CONFIG_SVH

// stream and queue sizing
`define PF_DATA_W 128
`define PF_TAG_W 12
`define PF_RESULT_W 14
`define PF_KEYQ_DEPTH 4
`define PF_KEYQ_ALMOST 2
`define PF_RESQ_DEPTH 8

// header fields inside the start beat, lsb offsets
`define PF_ETHERTYPE_IPV4 16'h0800
`define PF_OFF_ETHERTYPE 96
`define PF_OFF_PROTO 72
`define PF_OFF_DPORT 32

// rule table, proto of zero is a wildcard
`define PF_RULE_COUNT 4
`define PF_RULE_PROTO_0 8'd6
`define PF_RULE_DPORT_0 16'd80
`define PF_RULE_PROTO_1 8'd17
`define PF_RULE_DPORT_1 16'd53
`define PF_RULE_PROTO_2 8'd6
`define PF_RULE_DPORT_2 16'd443
`define PF_RULE_PROTO_3 8'd0
`define PF_RULE_DPORT_3 16'd8080

`endif

/* design/pkt_filter_pkg.sv */
`default_nettype none

`include "pkt_filter_config.svh"

package pkt_filter_pkg;

	// one beat of the receive stream
	typedef struct packed {
		logic sop;
		logic eop;
		logic [`PF_TAG_W-1:0] tag;
		logic [`PF_DATA_W-1:0] data;
	} beat_t;

	// lookup key queued per packet
	typedef struct packed {
		logic is_ipv4;
		logic [7:0] proto;
		logic [15:0] dport;
		logic [`PF_TAG_W-1:0] tag;
	} key_t;

	// matcher output, tag follows the key
	typedef struct packed {
		logic hit;
		logic [`PF_TAG_W-1:0] tag;
	} match_t;

endpackage

`default_nettype wire

/* design/showahead_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module showahead_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 4,
	parameter int ALMOST = 2
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic push,
	input wire logic [WIDTH-1:0] din,
	input wire logic pop,
	output logic [WIDTH-1:0] dout,
	output logic empty,
	output logic full,
	output logic almost_full
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= din;
		end
	end

	// pointers wrap at DEPTH, which need not be a power of two
	always_ff @(posedge clock) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// head is read straight from the array
	assign dout = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign almost_full = (count >= CNT_W'(ALMOST));

endmodule

`default_nettype wire

/* design/header_extract.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_filter_config.svh"

module header_extract (
	input wire logic clock,
	input wire logic rst,
	input wire pkt_filter_pkg::beat_t beat,
	input wire logic beat_fire,
	output pkt_filter_pkg::key_t key,
	output logic key_valid
);

	logic is_ipv4_q;
	logic [7:0] proto_q;
	logic [15:0] dport_q;
	logic [`PF_TAG_W-1:0] tag_q;
	logic start_fire;
	logic end_fire;

	assign start_fire = beat_fire && beat.sop;
	assign end_fire = beat_fire && beat.eop;

	// header fields only come from the first beat
	always_ff @(posedge clock) begin
		if (start_fire) begin
			is_ipv4_q <= (beat.data[`PF_OFF_ETHERTYPE +: 16] == `PF_ETHERTYPE_IPV4);
			proto_q <= beat.data[`PF_OFF_PROTO +: 8];
			dport_q <= beat.data[`PF_OFF_DPORT +: 16];
		end
	end

	// tag rides on the last beat
	always_ff @(posedge clock) begin
		if (end_fire) begin
			tag_q <= beat.tag;
		end
	end

	// one pulse per packet, a cycle after the end beat
	always_ff @(posedge clock) begin
		if (rst) begin
			key_valid <= 1'b0;
		end else begin
			key_valid <= end_fire;
		end
	end

	always_comb begin
		key.is_ipv4 = is_ipv4_q;
		key.proto = proto_q;
		key.dport = dport_q;
		key.tag = tag_q;
	end

endmodule

`default_nettype wire

/* design/rule_matcher.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_filter_config.svh"

module rule_matcher (
	input wire logic clock,
	input wire logic rst,
	input wire pkt_filter_pkg::key_t key,
	input wire logic key_take,
	input wire logic advance,
	output pkt_filter_pkg::match_t result,
	output logic result_valid
);

	localparam logic [7:0] RULE_PROTO [`PF_RULE_COUNT] = '{
		`PF_RULE_PROTO_0, `PF_RULE_PROTO_1, `PF_RULE_PROTO_2, `PF_RULE_PROTO_3
	};
	localparam logic [15:0] RULE_DPORT [`PF_RULE_COUNT] = '{
		`PF_RULE_DPORT_0, `PF_RULE_DPORT_1, `PF_RULE_DPORT_2, `PF_RULE_DPORT_3
	};

	logic [`PF_RULE_COUNT-1:0] rule_hit;
	logic [`PF_RULE_COUNT-1:0] s1_hit;
	logic s1_ipv4;
	logic [`PF_TAG_W-1:0] s1_tag;
	logic s1_valid;

	// compare against every rule in parallel
	always_comb begin
		for (int i = 0; i < `PF_RULE_COUNT; i++) begin
			rule_hit[i] = ((RULE_PROTO[i] == 8'd0) || (RULE_PROTO[i] == key.proto))
				&& (RULE_DPORT[i] == key.dport);
		end
	end

	// stage one, per-rule hits
	always_ff @(posedge clock) begin
		if (advance) begin
			s1_hit <= rule_hit;
			s1_ipv4 <= key.is_ipv4;
			s1_tag <= key.tag;
		end
	end

	// stage two, any rule on an ipv4 packet
	always_ff @(posedge clock) begin
		if (advance) begin
			result.hit <= s1_ipv4 && (|s1_hit);
			result.tag <= s1_tag;
		end
	end

	// valid bits hold with the data on a stall
	always_ff @(posedge clock) begin
		if (rst) begin
			s1_valid <= 1'b0;
			result_valid <= 1'b0;
		end else if (advance) begin
			s1_valid <= key_take;
			result_valid <= s1_valid;
		end
	end

endmodule

`default_nettype wire

/* design/filter_control.sv */
`timescale 1ns/1ps
`default_nettype none

module filter_control (
	input wire logic clock,
	input wire logic rst,
	input wire logic key_valid,
	input wire logic keyq_empty,
	input wire logic keyq_almost,
	input wire logic resq_full,
	input wire pkt_filter_pkg::match_t result,
	input wire logic result_valid,
	input wire logic beat_valid,
	output logic beat_ready,
	output logic beat_fire,
	output logic keyq_push,
	output logic key_take,
	output logic advance,
	output logic resq_push
);

	logic stall;

	// registered ready, the two spare slots cover the lag
	always_ff @(posedge clock) begin
		if (rst) begin
			beat_ready <= 1'b0;
		end else begin
			beat_ready <= !keyq_almost;
		end
	end

	assign beat_fire = beat_valid && beat_ready;

	// key queue never overflows since ready drops at almost full
	assign keyq_push = key_valid;

	// only a hit that cannot be stored holds the matcher
	assign stall = result_valid && result.hit && resq_full;
	assign advance = !stall;

	assign key_take = !keyq_empty && advance;

	// misses fall out of the last stage here
	assign resq_push = result_valid && result.hit && !resq_full;

endmodule

`default_nettype wire

/* design/packet_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_filter_config.svh"

module packet_filter_top (
	input wire logic clock,
	input wire logic rst,
	input wire pkt_filter_pkg::beat_t beat,
	input wire logic beat_valid,
	output logic beat_ready,
	output logic [`PF_RESULT_W-1:0] data_out,
	output logic data_valid,
	input wire logic data_ack
);

	pkt_filter_pkg::key_t key;
	pkt_filter_pkg::key_t keyq_head;
	pkt_filter_pkg::match_t result;
	logic key_valid;
	logic beat_fire;
	logic keyq_push;
	logic keyq_empty;
	logic keyq_almost;
	logic key_take;
	logic advance;
	logic result_valid;
	logic resq_push;
	logic resq_pop;
	logic resq_full;
	logic resq_empty;
	logic [`PF_RESULT_W-1:0] result_word;

	// destination bits lead the tag
	assign result_word = {result.tag[`PF_TAG_W-1 -: 2], result.tag};
	assign data_valid = !resq_empty;
	assign resq_pop = data_ack && data_valid;

	header_extract u_extract (
		.clock(clock),
		.rst(rst),
		.beat(beat),
		.beat_fire(beat_fire),
		.key(key),
		.key_valid(key_valid)
	);

	showahead_fifo #(
		.WIDTH($bits(pkt_filter_pkg::key_t)),
		.DEPTH(`PF_KEYQ_DEPTH),
		.ALMOST(`PF_KEYQ_ALMOST)
	) key_q (
		.clock(clock),
		.rst(rst),
		.push(keyq_push),
		.din(key),
		.pop(key_take),
		.dout(keyq_head),
		.empty(keyq_empty),
		.full(),
		.almost_full(keyq_almost)
	);

	rule_matcher u_matcher (
		.clock(clock),
		.rst(rst),
		.key(keyq_head),
		.key_take(key_take),
		.advance(advance),
		.result(result),
		.result_valid(result_valid)
	);

	filter_control u_control (
		.clock(clock),
		.rst(rst),
		.key_valid(key_valid),
		.keyq_empty(keyq_empty),
		.keyq_almost(keyq_almost),
		.resq_full(resq_full),
		.result(result),
		.result_valid(result_valid),
		.beat_valid(beat_valid),
		.beat_ready(beat_ready),
		.beat_fire(beat_fire),
		.keyq_push(keyq_push),
		.key_take(key_take),
		.advance(advance),
		.resq_push(resq_push)
	);

	showahead_fifo #(
		.WIDTH(`PF_RESULT_W),
		.DEPTH(`PF_RESQ_DEPTH),
		.ALMOST(`PF_RESQ_DEPTH)
	) res_q (
		.clock(clock),
		.rst(rst),
		.push(resq_push),
		.din(result_word),
		.pop(resq_pop),
		.dout(data_out),
		.empty(resq_empty),
		.full(resq_full),
		.almost_full()
	);

endmodule

`default_nettype wire

/* verif/packet_filter_props.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_filter_props (
	input wire logic clock,
	input wire logic rst,
	input wire logic beat_ready,
	input wire logic keyq_push,
	input wire logic keyq_full,
	input wire logic keyq_empty,
	input wire logic key_take,
	input wire logic advance,
	input wire logic resq_push,
	input wire logic resq_full,
	input wire logic resq_pop,
	input wire logic resq_empty
);

	// neither queue overflows or underflows
	assert property (@(posedge clock) disable iff (rst) !(keyq_push && keyq_full))
		else $error("push into a full key queue");
	assert property (@(posedge clock) disable iff (rst) !(resq_push && resq_full))
		else $error("push into a full result queue");
	assert property (@(posedge clock) disable iff (rst) !(key_take && keyq_empty))
		else $error("pop from an empty key queue");
	assert property (@(posedge clock) disable iff (rst) !(resq_pop && resq_empty))
		else $error("pop from an empty result queue");

	// ready held low while in reset
	assert property (@(posedge clock) rst |=> !beat_ready)
		else $error("beat_ready high during reset");

	// a stalled matcher takes no key
	assert property (@(posedge clock) disable iff (rst) !(key_take && !advance))
		else $error("key taken while the matcher is stalled");

endmodule

bind packet_filter_top packet_filter_props props (
	.clock(clock),
	.rst(rst),
	.beat_ready(beat_ready),
	.keyq_push(keyq_push),
	.keyq_full(key_q.full),
	.keyq_empty(keyq_empty),
	.key_take(key_take),
	.advance(advance),
	.resq_push(resq_push),
	.resq_full(resq_full),
	.resq_pop(resq_pop),
	.resq_empty(resq_empty)
);

`default_nettype wire

/* verif/packet_filter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pkt_filter_config.svh"

module packet_filter_tb;

	localparam int NUM_PACKETS = 8 + 12 + 6 + 20 + 200;
	localparam int CYCLE_LIMIT = 40 * NUM_PACKETS + 200;

	logic clock;
	logic rst;
	pkt_filter_pkg::beat_t beat;
	logic beat_valid;
	logic beat_ready;
	logic [`PF_RESULT_W-1:0] data_out;
	logic data_valid;
	logic data_ack;

	logic [31:0] seed;
	logic [31:0] ack_seed;
	logic [31:0] draw;
	logic [`PF_RESULT_W-1:0] exp_q [$];
	logic [`PF_RESULT_W-1:0] exp_word;
	logic [1:0] ack_mode;
	int cycles = 0;
	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_errors = 0;
	int words_out = 0;
	int beats_taken = 0;
	int base_beats;
	int base_words;
	int held;
	int wait_count;

	packet_filter_top DUT (
		.clock(clock),
		.rst(rst),
		.beat(beat),
		.beat_valid(beat_valid),
		.beat_ready(beat_ready),
		.data_out(data_out),
		.data_valid(data_valid),
		.data_ack(data_ack)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic next_rand(output logic [31:0] r);
		seed = lcg(seed);
		r = seed;
	endtask

	function automatic logic [7:0] rule_proto(input int idx);
		case (idx)
			0: return `PF_RULE_PROTO_0;
			1: return `PF_RULE_PROTO_1;
			2: return `PF_RULE_PROTO_2;
			default: return `PF_RULE_PROTO_3;
		endcase
	endfunction

	function automatic logic [15:0] rule_dport(input int idx);
		case (idx)
			0: return `PF_RULE_DPORT_0;
			1: return `PF_RULE_DPORT_1;
			2: return `PF_RULE_DPORT_2;
			default: return `PF_RULE_DPORT_3;
		endcase
	endfunction

	// a hit needs an ipv4 packet and any matching rule
	function automatic logic predict_hit(input logic [15:0] etype, input logic [7:0] proto,
			input logic [15:0] dport);
		logic any_rule;
		any_rule = 1'b0;
		for (int i = 0; i < `PF_RULE_COUNT; i++) begin
			if ((rule_proto(i) == 8'd0 || rule_proto(i) == proto) && rule_dport(i) == dport) begin
				any_rule = 1'b1;
			end
		end
		return any_rule && (etype == `PF_ETHERTYPE_IPV4);
	endfunction

	// runs from 2 ns after one edge to 2 ns after the accepting edge
	task automatic drive_beat(input pkt_filter_pkg::beat_t b);
		logic taken;
		beat = b;
		beat_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			taken = beat_ready;
			@(posedge clock);
			#2;
		end
	endtask

	task automatic idle_cycles(input int n);
		beat_valid = 1'b0;
		repeat (n) begin
			@(posedge clock);
			#2;
		end
	endtask

	task automatic send_packet(input int nbeats, input logic [15:0] etype,
			input logic [7:0] proto, input logic [15:0] dport, input logic [11:0] tag);
		pkt_filter_pkg::beat_t b;
		logic [31:0] r;
		if (predict_hit(etype, proto, dport)) begin
			exp_q.push_back({tag[`PF_TAG_W-1 -: 2], tag});
		end
		for (int i = 0; i < nbeats; i++) begin
			// later beats carry junk headers and tags
			for (int w = 0; w < 4; w++) begin
				next_rand(r);
				b.data[w*32 +: 32] = r;
			end
			next_rand(r);
			b.tag = r[27:16];
			b.sop = (i == 0);
			b.eop = (i == nbeats - 1);
			if (b.sop) begin
				b.data[`PF_OFF_ETHERTYPE +: 16] = etype;
				b.data[`PF_OFF_PROTO +: 8] = proto;
				b.data[`PF_OFF_DPORT +: 16] = dport;
			end
			if (b.eop) begin
				b.tag = tag;
			end
			drive_beat(b);
		end
		beat_valid = 1'b0;
	endtask

	// kind 0 hit, 1 wrong port, 2 not ipv4, 3 random fields
	task automatic send_kind(input int kind, input int idx, input int nbeats);
		logic [31:0] r;
		logic [15:0] etype;
		logic [7:0] proto;
		logic [15:0] dport;
		next_rand(r);
		etype = `PF_ETHERTYPE_IPV4;
		proto = (rule_proto(idx) == 8'd0) ? r[31:24] : rule_proto(idx);
		dport = rule_dport(idx);
		if (kind == 1) begin
			dport = dport ^ 16'h0100;
		end else if (kind == 2) begin
			etype = 16'h86dd;
		end else if (kind == 3) begin
			proto = r[23:16];
			dport = r[31:16];
		end
		next_rand(r);
		send_packet(nbeats, etype, proto, dport, r[27:16]);
	endtask

	task automatic drain;
		ack_mode = 2'd0;
		while (exp_q.size() != 0) begin
			@(posedge clock);
			#2;
		end
		// trailing misses still flow out of the matcher
		idle_cycles(8);
		checks++;
		if (data_valid) begin
			$display("Error at %0t: word %h left in the output queue", $time, data_out);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		tests++;
		if (errors == test_errors) begin
			$display("test %0s: pass", name);
		end else begin
			$display("test %0s: %0d errors", name, errors - test_errors);
		end
		test_errors = errors;
	endtask

	// ack level for the DUT to sample on the next edge
	always @(posedge clock) begin
		#2;
		ack_seed = lcg(ack_seed);
		case (ack_mode)
			2'd0: data_ack = 1'b1;
			2'd1: data_ack = 1'b0;
			default: data_ack = ack_seed[31];
		endcase
	end

	// scoreboard samples mid cycle where all levels are settled
	always @(negedge clock) begin
		if (!rst && beat_valid && beat_ready) begin
			beats_taken++;
		end
		if (!rst && data_valid && data_ack) begin
			words_out++;
			checks++;
			if (exp_q.size() == 0) begin
				$display("Error at %0t: unexpected output word %h", $time, data_out);
				errors++;
			end else begin
				exp_word = exp_q.pop_front();
				if (data_out !== exp_word) begin
					$display("Error at %0t: expected %h, got %h", $time, exp_word, data_out);
					errors++;
				end
			end
		end
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles, %0d words never came out",
				cycles, exp_q.size());
			$display("CHECKS FAILED");
			$finish;
		end
	end

	initial begin
		rst = 1'b1;
		beat = '0;
		beat_valid = 1'b0;
		data_ack = 1'b0;
		ack_mode = 2'd0;
		seed = 32'h58a7a5f0;
		ack_seed = 32'h58a7a5f0;
		repeat (3) @(posedge clock);
		#2;
		checks++;
		if (beat_ready !== 1'b0 || data_valid !== 1'b0) begin
			$display("Error at %0t: beat_ready %b data_valid %b in reset", $time,
				beat_ready, data_valid);
			errors++;
		end
		rst = 1'b0;
		wait_count = 0;
		while (!beat_ready && wait_count < 4) begin
			@(posedge clock);
			#2;
			wait_count++;
		end
		checks++;
		if (!beat_ready) begin
			$display("beat_ready never rose after reset was released");
			errors++;
		end
		report_test("reset");

		for (int i = 0; i < 8; i++) begin
			send_kind(0, i % 4, 1);
		end
		drain;
		report_test("rule hits");

		for (int i = 0; i < 12; i++) begin
			send_kind(i % 3, i % 4, 1);
		end
		drain;
		report_test("misses and non-ipv4");

		for (int i = 0; i < 6; i++) begin
			send_kind((i == 3) ? 2 : 0, i % 4, 2 + i % 2);
			idle_cycles(i % 2);
		end
		drain;
		report_test("multi-beat");

		ack_mode = 2'd1;
		base_beats = beats_taken;
		base_words = words_out;
		fork
			begin
				for (int i = 0; i < 20; i++) begin
					send_kind(0, i % 4, 1);
				end
			end
			begin
				// wait for the key queue to push back on the input
				wait_count = 0;
				while (beat_ready && wait_count < 60) begin
					@(posedge clock);
					#2;
					wait_count++;
				end
				held = beats_taken;
				repeat (20) begin
					@(posedge clock);
					#2;
				end
				checks++;
				if (beat_ready || beats_taken != held || held - base_beats >= 20) begin
					$display("Error at %0t: %0d beats taken with output held", $time,
						beats_taken - base_beats);
					errors++;
				end
				ack_mode = 2'd0;
			end
		join
		drain;
		checks++;
		if (words_out - base_words != 20) begin
			$display("back-pressure test drained %0d words instead of 20",
				words_out - base_words);
			errors++;
		end
		report_test("back-pressure");

		ack_mode = 2'd2;
		for (int i = 0; i < 200; i++) begin
			next_rand(draw);
			send_kind(draw[31:30], draw[29:28], draw[27:24] % 3 + 1);
			idle_cycles(draw[23:20] % 3);
		end
		drain;
		report_test("random mix");

		$display("%0d tests run, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/pkt_filter_pkg.sv
design/showahead_fifo.sv
design/header_extract.sv
design/rule_matcher.sv
design/filter_control.sv
design/packet_filter_top.sv
verif/packet_filter_props.sv
verif/packet_filter_tb.sv

/* Bender.yml */
package:
  name: packet_filter

sources:
  - include_dirs:
      - design
    files:
      - design/pkt_filter_pkg.sv
      - design/showahead_fifo.sv
      - design/header_extract.sv
      - design/rule_matcher.sv
      - design/filter_control.sv
      - design/packet_filter_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verif/packet_filter_props.sv
      - verif/packet_filter_tb.sv
